// ==== design/trace_cfg.svh ====
`ifndef TRACE_CFG_SVH
`define TRACE_CFG_SVH

// Datapath and transmit word width
`define TRACE_WORD_W 32

// Debug panel mode selector
`define TRACE_MODE_W 8
`define TRACE_CMD 8'h54

// Number of datapath words in one transcript
`define TRACE_FIELD_CNT 9

// Separator and line end
`define TRACE_ASCII_EQ 8'h3D
`define TRACE_ASCII_CR 8'h0D
`define TRACE_ASCII_LF 8'h0A

`endif

// ==== design/trace_pkg.sv ====
`include "trace_cfg.svh"

package trace_pkg;

    // Print order of the datapath words
    typedef enum logic [3:0] {
        fld_npc,
        fld_pc,
        fld_ir,
        fld_ctl,
        fld_a,
        fld_b,
        fld_imm,
        fld_y,
        fld_mdr
    } field_e;

    typedef struct packed {
        logic [`TRACE_WORD_W-1:0] npc;
        logic [`TRACE_WORD_W-1:0] pc;
        logic [`TRACE_WORD_W-1:0] ir;
        logic [`TRACE_WORD_W-1:0] ctl;
        logic [`TRACE_WORD_W-1:0] a;
        logic [`TRACE_WORD_W-1:0] b;
        logic [`TRACE_WORD_W-1:0] imm;
        logic [`TRACE_WORD_W-1:0] y;
        logic [`TRACE_WORD_W-1:0] mdr;
    } dp_status_t;

    // Receiver reads either a raw datapath word or one character
    typedef union packed {
        logic [`TRACE_WORD_W-1:0] data;
        struct packed {
            logic [`TRACE_WORD_W-9:0] pad;   // Zero for characters
            logic [7:0]               code;  // ASCII
        } chr;
    } tx_word_u;

    typedef struct packed {
        logic     is_data;  // Low for a character
        tx_word_u word;
    } tx_item_t;

endpackage

// ==== design/trace_step_ctrl.sv ====
`timescale 1ns/1ps
`include "trace_cfg.svh"

module trace_step_ctrl (
    input  logic                     clk,
    input  logic                     rstn,
    input  logic [`TRACE_MODE_W-1:0] sel_mode,
    input  logic                     seq_done,
    output logic                     run,
    output logic                     clk_cpu,
    output logic                     finish
);

    localparam logic [2:0] st_idle    = 3'd0;
    localparam logic [2:0] st_step_hi = 3'd1;
    localparam logic [2:0] st_step_lo = 3'd2;
    localparam logic [2:0] st_running = 3'd3;
    localparam logic [2:0] st_done    = 3'd4;

    logic [2:0] state;
    logic [2:0] state_nx;
    logic       cmd_hit;
    logic       cmd_hit_q;

    assign cmd_hit = (sel_mode == `TRACE_CMD);

    always_comb begin
        state_nx = state;
        case (state)
            st_idle: begin
                if (cmd_hit_q) begin
                    state_nx = st_step_hi;
                end
            end
            st_step_hi: state_nx = st_step_lo;
            st_step_lo: state_nx = st_running;
            st_running: begin
                if (seq_done) begin
                    state_nx = st_done;
                end
            end
            st_done:    state_nx = st_done;  // Held until the selector moves
            default:    state_nx = st_idle;
        endcase
        if (!cmd_hit) begin
            state_nx = st_idle;  // Abort or release
        end
    end

    // Outputs come straight from flops so clk_cpu is glitch free
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state     <= st_idle;
            cmd_hit_q <= 1'b0;
            clk_cpu   <= 1'b0;
            run       <= 1'b0;
            finish    <= 1'b0;
        end else begin
            state     <= state_nx;
            cmd_hit_q <= cmd_hit;
            clk_cpu   <= (state_nx == st_step_hi);
            run       <= (state_nx == st_running);
            finish    <= (state_nx == st_done);
        end
    end

    a_single_step: assert property (@(posedge clk) disable iff (!rstn)
        clk_cpu |=> !clk_cpu);

endmodule

// ==== design/trace_item_seq.sv ====
`timescale 1ns/1ps
`include "trace_cfg.svh"

module trace_item_seq (
    input  logic                  clk,
    input  logic                  rstn,
    input  logic                  run,
    input  logic                  take,
    input  logic                  sent,
    input  trace_pkg::dp_status_t status,
    output trace_pkg::tx_item_t   next_item,
    output logic                  next_valid,
    output logic                  seq_done
);

    trace_pkg::field_e        fld;
    logic                     eol;         // CR/LF phase after the last field
    logic [2:0]               idx;         // Position inside the field
    logic                     all_staged;
    logic [1:0]               pending;     // Staged, not yet acknowledged
    logic [23:0]              lbl_text;
    logic [2:0]               lbl_len;
    logic [`TRACE_WORD_W-1:0] fld_word;
    trace_pkg::tx_item_t      cur_item;
    logic                     stage;

    // Label table, first character in the top used byte
    always_comb begin
        case (fld)
            trace_pkg::fld_npc: {lbl_text, lbl_len} = {24'("NPC"), 3'd3};
            trace_pkg::fld_pc:  {lbl_text, lbl_len} = {24'("PC"), 3'd2};
            trace_pkg::fld_ir:  {lbl_text, lbl_len} = {24'("IR"), 3'd2};
            trace_pkg::fld_ctl: {lbl_text, lbl_len} = {24'("CTL"), 3'd3};
            trace_pkg::fld_a:   {lbl_text, lbl_len} = {24'("A"), 3'd1};
            trace_pkg::fld_b:   {lbl_text, lbl_len} = {24'("B"), 3'd1};
            trace_pkg::fld_imm: {lbl_text, lbl_len} = {24'("IMM"), 3'd3};
            trace_pkg::fld_y:   {lbl_text, lbl_len} = {24'("Y"), 3'd1};
            trace_pkg::fld_mdr: {lbl_text, lbl_len} = {24'("MDR"), 3'd3};
            default:            {lbl_text, lbl_len} = '0;
        endcase
    end

    always_comb begin
        case (fld)
            trace_pkg::fld_npc: fld_word = status.npc;
            trace_pkg::fld_pc:  fld_word = status.pc;
            trace_pkg::fld_ir:  fld_word = status.ir;
            trace_pkg::fld_ctl: fld_word = status.ctl;
            trace_pkg::fld_a:   fld_word = status.a;
            trace_pkg::fld_b:   fld_word = status.b;
            trace_pkg::fld_imm: fld_word = status.imm;
            trace_pkg::fld_y:   fld_word = status.y;
            trace_pkg::fld_mdr: fld_word = status.mdr;
            default:            fld_word = '0;
        endcase
    end

    // Item at the current position
    always_comb begin
        cur_item = '0;
        if (eol) begin
            cur_item.word.chr.code = (idx == 3'd0) ? `TRACE_ASCII_CR : `TRACE_ASCII_LF;
        end else if (idx < lbl_len) begin
            cur_item.word.chr.code = lbl_text[8*(lbl_len-idx-1) +: 8];
        end else if (idx == lbl_len) begin
            cur_item.word.chr.code = `TRACE_ASCII_EQ;
        end else begin
            cur_item.is_data   = 1'b1;
            cur_item.word.data = fld_word;
        end
    end

    assign stage    = run && !next_valid && !all_staged;
    assign seq_done = sent && all_staged && (pending == 2'd1);  // LF acknowledged

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            fld        <= trace_pkg::fld_npc;
            eol        <= 1'b0;
            idx        <= '0;
            all_staged <= 1'b0;
            pending    <= '0;
            next_valid <= 1'b0;
        end else if (!run) begin
            fld        <= trace_pkg::fld_npc;  // Next run starts at the NPC label
            eol        <= 1'b0;
            idx        <= '0;
            all_staged <= 1'b0;
            pending    <= '0;
            next_valid <= 1'b0;
        end else begin
            if (stage) begin
                next_valid <= 1'b1;
                if (eol) begin
                    if (idx == 3'd0) begin
                        idx <= 3'd1;
                    end else begin
                        all_staged <= 1'b1;
                    end
                end else if (idx <= lbl_len) begin
                    idx <= idx + 3'd1;
                end else begin
                    idx <= '0;
                    if (fld == trace_pkg::fld_mdr) begin
                        eol <= 1'b1;
                    end else begin
                        fld <= trace_pkg::field_e'(fld + 4'd1);
                    end
                end
            end else if (take) begin
                next_valid <= 1'b0;
            end
            pending <= pending + 2'(stage) - 2'(sent);
        end
    end

    always_ff @(posedge clk) begin
        if (stage) begin
            next_item <= cur_item;
        end
    end

    a_field_range: assert property (@(posedge clk) disable iff (!rstn)
        int'(fld) < `TRACE_FIELD_CNT);

    // Offered item holds until the port takes it
    a_item_hold: assert property (@(posedge clk) disable iff (!rstn)
        next_valid && !take |=> $stable(next_item));

endmodule

// ==== design/trace_tx_port.sv ====
`timescale 1ns/1ps
`include "trace_cfg.svh"

module trace_tx_port (
    input  logic                clk,
    input  logic                rstn,
    input  logic                run,
    input  logic                next_valid,
    input  logic                tx_ack,
    input  trace_pkg::tx_item_t next_item,
    output logic                take,
    output logic                sent,
    output logic                tx_req,
    output trace_pkg::tx_item_t tx_item
);

    // tx_req doubles as the occupancy flag of the output slot
    assign take = run && next_valid && !tx_req;
    assign sent = tx_req && tx_ack;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            tx_req <= 1'b0;
        end else if (!run) begin
            tx_req <= 1'b0;  // Flush on abort or finish
        end else if (take) begin
            tx_req <= 1'b1;
        end else if (sent) begin
            tx_req <= 1'b0;  // Low for a cycle before the next item
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            tx_item <= next_item;
        end
    end

    // Request and word hold while the transmitter stalls
    a_req_hold: assert property (@(posedge clk) disable iff (!rstn)
        tx_req && !tx_ack && run |=> tx_req && $stable(tx_item));

endmodule

// ==== design/trace_top.sv ====
`timescale 1ns/1ps
`include "trace_cfg.svh"

module trace_top (
    input  logic                     clk,
    input  logic                     rstn,
    input  logic [`TRACE_MODE_W-1:0] sel_mode,
    input  trace_pkg::dp_status_t    status,    // Held while the CPU is stopped
    input  logic                     tx_ack,
    output logic                     tx_req,
    output trace_pkg::tx_item_t      tx_item,
    output logic                     finish,
    output logic                     clk_cpu
);

    logic                run;
    logic                seq_done;
    logic                next_valid;
    logic                take;
    logic                sent;
    trace_pkg::tx_item_t next_item;

    trace_step_ctrl i_step_ctrl (
        .clk      (clk),
        .rstn     (rstn),
        .sel_mode (sel_mode),
        .seq_done (seq_done),
        .run      (run),
        .clk_cpu  (clk_cpu),
        .finish   (finish)
    );

    trace_item_seq i_item_seq (
        .clk        (clk),
        .rstn       (rstn),
        .run        (run),
        .take       (take),
        .sent       (sent),
        .status     (status),
        .next_item  (next_item),
        .next_valid (next_valid),
        .seq_done   (seq_done)
    );

    trace_tx_port i_tx_port (
        .clk        (clk),
        .rstn       (rstn),
        .run        (run),
        .next_valid (next_valid),
        .tx_ack     (tx_ack),
        .next_item  (next_item),
        .take       (take),
        .sent       (sent),
        .tx_req     (tx_req),
        .tx_item    (tx_item)
    );

endmodule

// ==== verification/tb_clk_gen.sv ====
`timescale 1ns/1ps

module tb_clk_gen #(
    parameter real PERIOD_NS  = 10.0,
    parameter int  RST_CYCLES = 3
) (
    output logic clk,
    output logic rstn
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2.0) clk = ~clk;
    end

    initial begin
        rstn = 1'b0;
        repeat (RST_CYCLES) @(posedge clk);
        #1;
        rstn = 1'b1;  // Released with the other inputs
    end

endmodule

// ==== verification/trace_tb.sv ====
`timescale 1ns/1ps
`include "trace_cfg.svh"

module trace_tb;

    localparam int N_ITEMS   = 39;
    localparam int N_TESTS   = 6;
    localparam int CLK_NS    = 10;
    localparam int WDOG_NS   = N_TESTS * N_ITEMS * 8 * CLK_NS + 2000;
    localparam int FIN_LIMIT = N_ITEMS * 8;  // Cycles for one transcript

    logic                     clk;
    logic                     rstn;
    logic [`TRACE_MODE_W-1:0] sel_mode;
    trace_pkg::dp_status_t    status;
    logic                     tx_ack;
    logic                     tx_req;
    trace_pkg::tx_item_t      tx_item;
    logic                     finish;
    logic                     clk_cpu;

    logic [15:0]         lfsr;
    int                  ack_delay [N_ITEMS];
    int                  got_cnt;     // Acknowledged items in this transcript
    int                  cpu_pulses;
    int                  err_cnt;
    int                  test_err;
    int                  tests_run;
    int                  tests_failed;
    string               test_name;
    logic                hold_chk;
    logic                prev_req;
    logic                prev_ack;
    logic                prev_cpu;
    trace_pkg::tx_item_t prev_item;

    tb_clk_gen #(.PERIOD_NS(10.0), .RST_CYCLES(3)) i_clk_gen (.clk(clk), .rstn(rstn));

    trace_top i_dut (
        .clk      (clk),
        .rstn     (rstn),
        .sel_mode (sel_mode),
        .status   (status),
        .tx_ack   (tx_ack),
        .tx_req   (tx_req),
        .tx_item  (tx_item),
        .finish   (finish),
        .clk_cpu  (clk_cpu)
    );

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic rand_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v    = {v[30:0], lfsr[0]};
        end
    endtask

    function automatic string label_of(input int f);
        case (f)
            0:       return "NPC";
            1:       return "PC";
            2:       return "IR";
            3:       return "CTL";
            4:       return "A";
            5:       return "B";
            6:       return "IMM";
            7:       return "Y";
            default: return "MDR";
        endcase
    endfunction

    function automatic logic [31:0] word_of(input trace_pkg::dp_status_t st, input int f);
        case (f)
            0:       return st.npc;
            1:       return st.pc;
            2:       return st.ir;
            3:       return st.ctl;
            4:       return st.a;
            5:       return st.b;
            6:       return st.imm;
            7:       return st.y;
            default: return st.mdr;
        endcase
    endfunction

    function automatic trace_pkg::tx_item_t char_item(input logic [7:0] code);
        return {1'b0, 24'h0, code};
    endfunction

    // Item n of the transcript for status st
    function automatic trace_pkg::tx_item_t ref_item(input trace_pkg::dp_status_t st,
                                                     input int n);
        trace_pkg::tx_item_t it;
        string               lbl;
        int                  pos;
        it  = '0;
        pos = 0;
        for (int f = 0; f < `TRACE_FIELD_CNT; f++) begin
            lbl = label_of(f);
            for (int c = 0; c < lbl.len(); c++) begin
                if (pos == n) begin
                    it = char_item(lbl[c]);
                end
                pos++;
            end
            if (pos == n) begin
                it = char_item(`TRACE_ASCII_EQ);
            end
            if (pos + 1 == n) begin
                it = {1'b1, word_of(st, f)};
            end
            pos += 2;
        end
        if (pos == n) begin
            it = char_item(`TRACE_ASCII_CR);
        end
        if (pos + 1 == n) begin
            it = char_item(`TRACE_ASCII_LF);
        end
        return it;
    endfunction

    // Compares every acknowledged item and watches the handshake
    always @(posedge clk) begin : monitor
        trace_pkg::tx_item_t exp_item;
        if (rstn) begin
            if (tx_req && tx_ack) begin
                if (got_cnt >= N_ITEMS) begin
                    $display("%0d ns: more than %0d items acknowledged", $time, N_ITEMS);
                    err_cnt++;
                end else begin
                    exp_item = ref_item(status, got_cnt);
                    if (tx_item !== exp_item) begin
                        $display("[ERROR] %0d ns tx_item[%0d]: expected %h, got %h",
                                 $time, got_cnt, exp_item, tx_item);
                        err_cnt++;
                    end
                end
                got_cnt++;
            end
            if (hold_chk && prev_req && !prev_ack) begin
                if (!tx_req) begin
                    $display("%0d ns: tx_req dropped before tx_ack", $time);
                    err_cnt++;
                end else if (tx_item !== prev_item) begin
                    $display("[ERROR] %0d ns tx_item: expected %h, got %h while stalled",
                             $time, prev_item, tx_item);
                    err_cnt++;
                end
            end
            if (clk_cpu && prev_cpu) begin
                $display("%0d ns: clk_cpu high for more than one cycle", $time);
                err_cnt++;
            end
            if (clk_cpu && !prev_cpu) begin
                cpu_pulses++;
            end
            if (tx_req && cpu_pulses == 0) begin
                $display("%0d ns: tx_req raised before the clk_cpu pulse", $time);
                err_cnt++;
            end
        end
        prev_req  = tx_req;
        prev_ack  = tx_ack;
        prev_cpu  = clk_cpu;
        prev_item = tx_item;
    end

    // Transmitter side, acknowledges after the planned number of cycles
    initial begin : ack_model
        int wait_cycles;
        int idx;
        tx_ack      = 1'b0;
        wait_cycles = 0;
        forever begin
            @(posedge clk);
            #1;
            idx = (got_cnt < N_ITEMS) ? got_cnt : N_ITEMS - 1;
            if (!tx_req || tx_ack) begin
                tx_ack      = 1'b0;
                wait_cycles = 0;
            end else if (wait_cycles >= ack_delay[idx]) begin
                tx_ack = 1'b1;
            end else begin
                wait_cycles++;
            end
        end
    end

    initial begin : watchdog
        #(WDOG_NS);
        $display("%0d ns: watchdog expired after %0d ns", $time, WDOG_NS);
        $display("TB FAILED");
        $finish;
    end

    task automatic tick(input int n);
        repeat (n) @(posedge clk);
        #1;
    endtask

    task automatic begin_test(input string name);
        test_name  = name;
        test_err   = err_cnt;
        got_cnt    = 0;
        cpu_pulses = 0;
    endtask

    task automatic end_test();
        tests_run++;
        if (err_cnt == test_err) begin
            $display("test %-14s ok", test_name);
        end else begin
            tests_failed++;
            $display("test %-14s %0d errors", test_name, err_cnt - test_err);
        end
    endtask

    // Only called while the CPU is stopped
    task automatic new_status(input logic rand_ack);
        logic [31:0] v;
        for (int i = 0; i < `TRACE_FIELD_CNT; i++) begin
            rand_bits(32, v);
            status = {status[$bits(status)-33:0], v};  // First word lands in npc
        end
        for (int i = 0; i < N_ITEMS; i++) begin
            ack_delay[i] = 0;
            if (rand_ack) begin
                rand_bits(2, v);
                ack_delay[i] = int'(v[1:0]);
            end
        end
    endtask

    task automatic wait_finish();
        int n;
        n = 0;
        while (!finish && n < FIN_LIMIT) begin
            tick(1);
            n++;
        end
        if (!finish) begin
            $display("%0d ns: finish did not rise within %0d cycles", $time, FIN_LIMIT);
            err_cnt++;
        end
        if (got_cnt != N_ITEMS) begin
            $display("%0d ns: transcript had %0d items, not %0d", $time, got_cnt, N_ITEMS);
            err_cnt++;
        end
        if (cpu_pulses != 1) begin
            $display("%0d ns: %0d clk_cpu pulses instead of one", $time, cpu_pulses);
            err_cnt++;
        end
    endtask

    task automatic check_quiet(input int n, input logic fin_exp);
        repeat (n) begin
            tick(1);
            if (tx_req) begin
                $display("%0d ns: tx_req high with no transcript due", $time);
                err_cnt++;
            end
            if (clk_cpu) begin
                $display("%0d ns: unexpected clk_cpu pulse", $time);
                err_cnt++;
            end
            if (finish !== fin_exp) begin
                $display("[ERROR] %0d ns finish: expected %b, got %b", $time, fin_exp, finish);
                err_cnt++;
            end
        end
    endtask

    task automatic release_cmd();
        sel_mode = 8'h00;
        tick(1);
        if (finish) begin
            $display("%0d ns: finish still high after the selector changed", $time);
            err_cnt++;
        end
        check_quiet(3, 1'b0);
    endtask

    task automatic full_trace(input string name, input logic rand_ack);
        begin_test(name);
        new_status(rand_ack);
        sel_mode = `TRACE_CMD;
        wait_finish();
        release_cmd();
        end_test();
    endtask

    initial begin
        logic [31:0] v;
        int          n;
        lfsr         = 16'd91;
        sel_mode     = 8'h00;
        status       = '0;
        err_cnt      = 0;
        tests_run    = 0;
        tests_failed = 0;
        hold_chk     = 1'b1;
        prev_req     = 1'b0;
        prev_ack     = 1'b0;
        prev_cpu     = 1'b0;
        prev_item    = '0;
        ack_delay    = '{default: 0};
        got_cnt      = 0;
        cpu_pulses   = 0;
        wait (rstn);
        tick(1);

        begin_test("reset_idle");
        check_quiet(10, 1'b0);
        sel_mode = `TRACE_CMD + 8'd1;  // Neighbouring code must not start
        check_quiet(10, 1'b0);
        sel_mode = 8'h00;
        check_quiet(2, 1'b0);
        end_test();

        full_trace("zero_delay", 1'b0);
        full_trace("random_delay", 1'b1);

        begin_test("single_step");
        new_status(1'b1);
        sel_mode = `TRACE_CMD;
        tick(1);
        if (clk_cpu) begin
            $display("%0d ns: clk_cpu rose one cycle after the selection", $time);
            err_cnt++;
        end
        tick(1);
        if (!clk_cpu) begin
            $display("%0d ns: no clk_cpu pulse two cycles after the selection", $time);
            err_cnt++;
        end
        tick(1);
        n = 0;
        while (!tx_req && n < 3) begin
            tick(1);
            n++;
        end
        if (!tx_req) begin
            $display("%0d ns: tx_req not raised within 3 cycles of the step", $time);
            err_cnt++;
        end
        wait_finish();
        release_cmd();
        end_test();

        begin_test("finish_hold");
        new_status(1'b1);
        sel_mode = `TRACE_CMD;
        wait_finish();
        check_quiet(20, 1'b1);  // Held selection, no second transcript
        release_cmd();
        got_cnt    = 0;
        cpu_pulses = 0;
        new_status(1'b1);
        sel_mode = `TRACE_CMD;
        wait_finish();
        release_cmd();
        end_test();

        begin_test("abort");
        new_status(1'b1);
        rand_bits(4, v);
        sel_mode = `TRACE_CMD;
        n = 0;
        while (got_cnt < 5 + int'(v[3:0]) && n < FIN_LIMIT) begin
            tick(1);
            n++;
            if (finish) begin
                $display("%0d ns: finish high in the middle of a transcript", $time);
                err_cnt++;
            end
        end
        hold_chk = 1'b0;
        sel_mode = 8'h00;
        tick(2);
        if (tx_req) begin
            $display("%0d ns: tx_req still high two cycles after the abort", $time);
            err_cnt++;
        end
        check_quiet(10, 1'b0);
        hold_chk   = 1'b1;
        got_cnt    = 0;
        cpu_pulses = 0;
        sel_mode   = `TRACE_CMD;  // Restart from the NPC label
        wait_finish();
        release_cmd();
        end_test();

        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, err_cnt);
        if (err_cnt == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// ==== all.f ====
+incdir+design
design/trace_pkg.sv
design/trace_step_ctrl.sv
design/trace_item_seq.sv
design/trace_tx_port.sv
design/trace_top.sv
verification/tb_clk_gen.sv
verification/trace_tb.sv

// ==== Bender.yml ====
package:
  name: trace_unit

export_include_dirs:
  - design

sources:
  - include_dirs:
      - design
    files:
      - design/trace_pkg.sv
      - design/trace_step_ctrl.sv
      - design/trace_item_seq.sv
      - design/trace_tx_port.sv
      - design/trace_top.sv
  - target: simulation
    include_dirs:
      - design
    files:
      - verification/tb_clk_gen.sv
      - verification/trace_tb.sv
